/* vlog.f */
hdl/hdc_pkg.sv
hdl/item_generator.sv
hdl/hdc_core.sv
hdl/program_sequencer.sv
hdl/bundle_counter.sv
hdl/hdc_encoder_top.sv
tests/tb_hdc_encoder.sv

/* Makefile */
# Verilator flow for the HDC encoder

TOP = tb_hdc_encoder

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_hdc_encoder.sv */
module tb_hdc_encoder;

    localparam int DIM        = 128;
    localparam int ITEMS      = 64;
    localparam int PROG_DEPTH = 32;
    localparam int CREDITS    = 4;
    localparam int WPI        = DIM / 64;
    localparam int PA_W       = $clog2(PROG_DEPTH);
    localparam int AW         = hdc_pkg::ITEM_ADDR_W;
    localparam int WAIT_LIMIT = 200;
    // generation takes ITEMS*WPI cycles and no program runs past 100
    localparam int TIMEOUT_CYCLES = 4000;

    logic                  clk;
    logic                  reset;
    logic                  gen;
    logic                  start;
    logic                  prog_we;
    logic [PA_W-1:0]       prog_addr;
    hdc_pkg::instr_t       prog_data;
    logic                  credit_return = 1'b0;
    logic                  busy;
    logic                  done;
    logic                  result_valid;
    logic [DIM-1:0]        result_vec;
    logic                  last_pulse;

    // reference model
    logic [DIM-1:0]  model_mem [ITEMS];
    int              bundle_cnt [DIM];
    int              bundle_n;

    hdc_pkg::instr_t prog [$];
    logic [DIM-1:0]  exp_q [$];
    logic [DIM-1:0]  got_q [$];

    int errors;
    int checks;
    int seed;
    int cycle;
    int start_cyc;
    int done_cyc;
    int done_cnt;
    int last_cnt;
    int got_base;
    int done_base;
    int last_base;
    int credits_due;
    int credits_manual;
    int credits_sent;
    bit auto_credit;

    hdc_encoder_top #(
        .DIM        (DIM),
        .ITEMS      (ITEMS),
        .PROG_DEPTH (PROG_DEPTH),
        .CREDITS    (CREDITS)
    ) i_hdc_encoder_top (
        .clk           (clk),
        .reset         (reset),
        .gen           (gen),
        .start         (start),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .credit_return (credit_return),
        .busy          (busy),
        .done          (done),
        .result_valid  (result_valid),
        .result_vec    (result_vec),
        .last_pulse    (last_pulse)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // counters update on the rising edge and are stable by the falling edge
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (start) begin
            start_cyc = cycle;
        end
        if (result_valid) begin
            got_q.push_back(result_vec);
            if (auto_credit) begin
                credits_due = credits_due + 1;
            end
        end
        if (done) begin
            done_cnt = done_cnt + 1;
            done_cyc = cycle;
        end
        if (last_pulse) begin
            last_cnt = last_cnt + 1;
        end
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // host returns one credit pulse per consumed result
    always @(negedge clk) begin
        if (credits_sent < credits_due + credits_manual) begin
            credit_return = 1'b1;
            credits_sent  = credits_sent + 1;
        end else begin
            credit_return = 1'b0;
        end
    end

    function automatic logic [63:0] xs_next(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // bit 0 moves to the top
    function automatic logic [DIM-1:0] rotate_right(input logic [DIM-1:0] v);
        return (v >> 1) | (v << (DIM - 1));
    endfunction

    function automatic logic [DIM-1:0] rotate_left(input logic [DIM-1:0] v);
        return (v << 1) | (v >> (DIM - 1));
    endfunction

    function automatic int pick_item();
        return {$random(seed)} % ITEMS;
    endfunction

    task automatic check_vec(input string name, input logic [DIM-1:0] exp,
                             input logic [DIM-1:0] act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("FAILED %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        assert (act == exp)
        else begin
            errors++;
            $display("FAILED %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic add_instr(input hdc_pkg::opcode_t op, input int addr);
        hdc_pkg::instr_t ins;
        ins.op    = op;
        ins.addr  = AW'(addr);
        ins.spare = '0;
        prog.push_back(ins);
    endtask

    // every result also lands in the model bundle
    task automatic expect_store(input logic [DIM-1:0] v);
        exp_q.push_back(v);
        for (int i = 0; i < DIM; i++) begin
            if (v[i]) begin
                bundle_cnt[i]++;
            end
        end
        bundle_n++;
    endtask

    // strict majority with ties going to zero
    task automatic close_bundle(output logic [DIM-1:0] sign);
        for (int i = 0; i < DIM; i++) begin
            sign[i]       = (2 * bundle_cnt[i] > bundle_n);
            bundle_cnt[i] = 0;
        end
        bundle_n = 0;
    endtask

    task automatic clear_program();
        prog.delete();
        exp_q.delete();
    endtask

    task automatic start_program();
        for (int i = 0; i < prog.size(); i++) begin
            prog_we   = 1'b1;
            prog_addr = PA_W'(i);
            prog_data = prog[i];
            @(negedge clk);
        end
        prog_we   = 1'b0;
        got_base  = got_q.size();
        done_base = done_cnt;
        last_base = last_cnt;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_results(input int n, input string name);
        int t;
        t = 0;
        while (got_q.size() - got_base < n && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        assert (got_q.size() - got_base >= n)
        else begin
            errors++;
            $display("%s: timed out waiting for result %0d", name, n);
        end
    endtask

    task automatic wait_done(input string name);
        int t;
        t = 0;
        while (done_cnt == done_base && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        assert (done_cnt > done_base)
        else begin
            errors++;
            $display("%s: timed out waiting for done", name);
        end
        // let trailing results and credits drain
        repeat (8) @(negedge clk);
        check_count({name, " done pulses"}, 1, done_cnt - done_base);
    endtask

    task automatic compare_results(input string name);
        check_count({name, " result count"}, exp_q.size(), got_q.size() - got_base);
        for (int i = 0; i < exp_q.size(); i++) begin
            if (got_base + i < got_q.size()) begin
                check_vec(name, exp_q[i], got_q[got_base + i]);
            end
        end
    endtask

    task automatic fill_items();
        int          t;
        logic [63:0] s;
        gen = 1'b1;
        @(negedge clk);
        gen = 1'b0;
        t = 0;
        while (busy && t < ITEMS * WPI + WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        assert (!busy)
        else begin
            errors++;
            $display("item generation never finished");
        end
        // first word of each item in the low bits
        s = hdc_pkg::XS_SEED_DEFAULT;
        for (int k = 0; k < ITEMS; k++) begin
            for (int w = 0; w < WPI; w++) begin
                s = xs_next(s);
                model_mem[k][w*64 +: 64] = s;
            end
        end
    endtask

    task automatic reset_outputs_low();
        check_vec("reset outputs", '0, DIM'({result_valid, last_pulse, done, busy}));
    endtask

    task automatic load_store_items();
        int a;
        fill_items();
        clear_program();
        for (int i = 0; i < 4; i++) begin
            a = pick_item();
            add_instr(hdc_pkg::OP_LOAD, a);
            add_instr(hdc_pkg::OP_STORE, 0);
            expect_store(model_mem[a]);
        end
        add_instr(hdc_pkg::OP_HALT, 0);
        start_program();
        wait_done("load_store");
        compare_results("load_store");
    endtask

    task automatic ngram_sequence();
        int             a;
        int             b;
        int             c;
        int             d;
        logic [DIM-1:0] r1;
        logic [DIM-1:0] r2;
        a = pick_item();
        b = pick_item();
        c = pick_item();
        d = pick_item();
        clear_program();
        add_instr(hdc_pkg::OP_LOAD, a);
        add_instr(hdc_pkg::OP_RSHIFT, 0);
        add_instr(hdc_pkg::OP_MOVE, 0);
        add_instr(hdc_pkg::OP_LLSHIFT, b);
        add_instr(hdc_pkg::OP_LXOR, c);
        add_instr(hdc_pkg::OP_XOR, 0);
        // the trigram before the last load overwrites it
        add_instr(hdc_pkg::OP_STORE, 0);
        add_instr(hdc_pkg::OP_LRSHIFT, d);
        add_instr(hdc_pkg::OP_LSHIFT, 0);
        add_instr(hdc_pkg::OP_STORE, 0);
        add_instr(hdc_pkg::OP_HALT, 0);
        r2 = rotate_right(model_mem[a]);
        r1 = r2;
        r2 = model_mem[c] ^ rotate_left(model_mem[b]);
        r2 = r1 ^ r2;
        expect_store(r2);
        r2 = rotate_left(rotate_right(model_mem[d]));
        expect_store(r2);
        start_program();
        wait_done("ngram");
        // no bubbles and no stalls in this program
        check_count("ngram latency", prog.size() + 3, done_cyc - start_cyc);
        compare_results("ngram");
    endtask

    task automatic bundle_majority();
        int             a;
        int             e;
        logic [DIM-1:0] sign;
        clear_program();
        // close whatever earlier programs stored
        add_instr(hdc_pkg::OP_LAST, 0);
        close_bundle(sign);
        for (int i = 0; i < 3; i++) begin
            a = pick_item();
            add_instr(hdc_pkg::OP_LOAD, a);
            add_instr(hdc_pkg::OP_STORE, 0);
            expect_store(model_mem[a]);
        end
        add_instr(hdc_pkg::OP_LAST, 0);
        close_bundle(sign);
        add_instr(hdc_pkg::OP_SIGN, 0);
        add_instr(hdc_pkg::OP_STORE, 0);
        expect_store(sign);
        e = pick_item();
        add_instr(hdc_pkg::OP_WB, e);
        model_mem[e] = sign;
        add_instr(hdc_pkg::OP_LOAD, e);
        add_instr(hdc_pkg::OP_STORE, 0);
        expect_store(model_mem[e]);
        add_instr(hdc_pkg::OP_HALT, 0);
        start_program();
        wait_done("bundle");
        compare_results("bundle");
        check_count("bundle last pulses", 2, last_cnt - last_base);
    endtask

    task automatic credit_backpressure();
        int a;
        auto_credit = 1'b0;
        clear_program();
        for (int i = 0; i < 6; i++) begin
            a = pick_item();
            add_instr(hdc_pkg::OP_LOAD, a);
            add_instr(hdc_pkg::OP_STORE, 0);
            expect_store(model_mem[a]);
        end
        add_instr(hdc_pkg::OP_HALT, 0);
        start_program();
        wait_results(CREDITS, "credits");
        // nothing more may appear without a credit
        repeat (20) @(negedge clk);
        check_count("credits held", CREDITS, got_q.size() - got_base);
        for (int i = CREDITS; i < 6; i++) begin
            @(posedge clk);
            credits_manual = credits_manual + 1;
            @(negedge clk);
            wait_results(i + 1, "credits");
            // one credit lets exactly one more result through
            repeat (10) @(negedge clk);
            check_count("credits one per pulse", i + 1, got_q.size() - got_base);
        end
        wait_done("credits");
        compare_results("credits");
    endtask

    initial begin
        seed        = 61;
        auto_credit = 1'b1;
        reset       = 1'b1;
        gen         = 1'b0;
        start       = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        reset_outputs_low();
        load_store_items();
        ngram_sequence();
        bundle_majority();
        credit_backpressure();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* hdl/hdc_encoder_top.sv */
module hdc_encoder_top #(
    parameter int          DIM        = 128,
    parameter int          ITEMS      = 64,
    parameter int          PROG_DEPTH = 32,
    parameter int          CREDITS    = 4,
    parameter int          COUNT_W    = 6,
    parameter logic [63:0] SEED       = hdc_pkg::XS_SEED_DEFAULT
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          gen,
    input  logic                          start,
    input  logic                          prog_we,
    input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
    input  hdc_pkg::instr_t               prog_data,
    input  logic                          credit_return,
    output logic                          busy,
    output logic                          done,
    output logic                          result_valid,
    output logic [DIM-1:0]                result_vec,
    output logic                          last_pulse
);

    // item generator to core write port
    logic                            gen_we;
    logic [hdc_pkg::ITEM_ADDR_W-1:0] gen_addr;
    logic [DIM-1:0]                  gen_vec;
    logic                            gen_busy;

    // sequencer to core
    logic            issue_valid;
    hdc_pkg::instr_t issue;

    logic [DIM-1:0] sign_vec;

    item_generator #(
        .DIM   (DIM),
        .ITEMS (ITEMS),
        .SEED  (SEED)
    ) i_item_generator (
        .clk      (clk),
        .reset    (reset),
        .gen      (gen),
        .gen_we   (gen_we),
        .gen_addr (gen_addr),
        .gen_vec  (gen_vec),
        .gen_busy (gen_busy)
    );

    program_sequencer #(
        .PROG_DEPTH (PROG_DEPTH),
        .CREDITS    (CREDITS)
    ) i_program_sequencer (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .credit_return (credit_return),
        .gen_busy      (gen_busy),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .busy          (busy),
        .done          (done)
    );

    hdc_core #(
        .DIM   (DIM),
        .ITEMS (ITEMS)
    ) i_hdc_core (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .gen_we      (gen_we),
        .gen_addr    (gen_addr),
        .gen_vec     (gen_vec),
        .sign_vec    (sign_vec),
        .res_valid   (result_valid),
        .res_vec     (result_vec),
        .last_out    (last_pulse)
    );

    // sees every result the host sees
    bundle_counter #(
        .DIM     (DIM),
        .COUNT_W (COUNT_W)
    ) i_bundle_counter (
        .clk       (clk),
        .reset     (reset),
        .res_valid (result_valid),
        .res_vec   (result_vec),
        .last_out  (last_pulse),
        .sign_vec  (sign_vec)
    );

endmodule

/* hdl/bundle_counter.sv */
module bundle_counter #(
    parameter int DIM     = 128,
    parameter int COUNT_W = 6
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           res_valid,
    input  logic [DIM-1:0] res_vec,
    input  logic           last_out,
    output logic [DIM-1:0] sign_vec
);

    localparam logic [COUNT_W-1:0] CNT_MAX = '1;

    // one counter per bit position
    logic [COUNT_W-1:0] bit_cnt [DIM];
    logic [COUNT_W-1:0] store_cnt;
    logic [DIM-1:0]     majority;

    // strict majority, a tie gives zero
    always_comb begin
        for (int i = 0; i < DIM; i++) begin
            majority[i] = {bit_cnt[i], 1'b0} > {1'b0, store_cnt};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DIM; i++) begin
                bit_cnt[i] <= '0;
            end
            store_cnt <= '0;
            sign_vec  <= '0;
        end else if (last_out) begin
            // close the bundle and start a fresh one
            sign_vec <= majority;
            for (int i = 0; i < DIM; i++) begin
                bit_cnt[i] <= '0;
            end
            store_cnt <= '0;
        end else if (res_valid) begin
            for (int i = 0; i < DIM; i++) begin
                if (res_vec[i] && bit_cnt[i] != CNT_MAX) begin
                    bit_cnt[i] <= bit_cnt[i] + 1'b1;
                end
            end
            if (store_cnt != CNT_MAX) begin
                store_cnt <= store_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/program_sequencer.sv */
module program_sequencer #(
    parameter int PROG_DEPTH = 32,
    parameter int CREDITS    = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          prog_we,
    input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
    input  hdc_pkg::instr_t               prog_data,
    input  logic                          credit_return,
    input  logic                          gen_busy,
    output logic                          issue_valid,
    output hdc_pkg::instr_t               issue,
    output logic                          busy,
    output logic                          done
);

    localparam int PA_W = $clog2(PROG_DEPTH);
    localparam int CR_W = $clog2(CREDITS + 1);

    hdc_pkg::instr_t prog_mem [PROG_DEPTH];

    logic            running;
    logic            bubble;
    logic            halt_d1;
    logic [PA_W-1:0] pc;
    logic [CR_W-1:0] credits;
    hdc_pkg::instr_t cur;
    logic            store_hold;
    logic            go;
    logic            halt_issued;

    assign cur         = prog_mem[pc];
    // a store waits here for a credit
    assign store_hold  = (cur.op == hdc_pkg::OP_STORE) && (credits == '0);
    assign go          = running && !bubble && !store_hold;
    assign halt_issued = issue_valid && (issue.op == hdc_pkg::OP_HALT);
    assign busy        = gen_busy | running | halt_issued | halt_d1;

    always_ff @(posedge clk) begin
        if (prog_we && !busy) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running     <= 1'b0;
            bubble      <= 1'b0;
            halt_d1     <= 1'b0;
            pc          <= '0;
            issue_valid <= 1'b0;
            done        <= 1'b0;
        end else begin
            issue_valid <= go;
            bubble      <= 1'b0;
            halt_d1     <= halt_issued;
            // done lines up with the cycle halt would execute
            done        <= halt_d1;
            if (start && !busy) begin
                running <= 1'b1;
                pc      <= '0;
            end else if (go) begin
                pc <= pc + 1'b1;
                if (cur.op == hdc_pkg::OP_WB || cur.op == hdc_pkg::OP_LAST) begin
                    bubble <= 1'b1;
                end
                if (cur.op == hdc_pkg::OP_HALT) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            issue <= cur;
        end
    end

    // a returned credit shows up one cycle later, capped at CREDITS
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CR_W'(CREDITS);
        end else if (go && cur.op == hdc_pkg::OP_STORE) begin
            if (!credit_return) begin
                credits <= credits - 1'b1;
            end
        end else if (credit_return && credits != CR_W'(CREDITS)) begin
            credits <= credits + 1'b1;
        end
    end

endmodule

/* hdl/hdc_core.sv */
module hdc_core #(
    parameter int DIM   = 128,
    parameter int ITEMS = 64
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            issue_valid,
    input  hdc_pkg::instr_t                 issue,
    input  logic                            gen_we,
    input  logic [hdc_pkg::ITEM_ADDR_W-1:0] gen_addr,
    input  logic [DIM-1:0]                  gen_vec,
    input  logic [DIM-1:0]                  sign_vec,
    output logic                            res_valid,
    output logic [DIM-1:0]                  res_vec,
    output logic                            last_out
);

    localparam int IA_W = (ITEMS > 1) ? $clog2(ITEMS) : 1;

    logic [DIM-1:0] item_mem [ITEMS];

    // stage 1 holds the decoded instruction
    logic            s1_valid;
    hdc_pkg::instr_t s1_instr;

    // stage 2 executes against reg_0
    logic            s2_valid;
    hdc_pkg::instr_t s2_instr;

    logic [DIM-1:0] reg_0;
    logic [DIM-1:0] reg_1;
    logic [DIM-1:0] reg_2;
    logic           wb_en;

    // bit 0 wraps to the top
    function automatic logic [DIM-1:0] rot_r(input logic [DIM-1:0] v);
        return {v[0], v[DIM-1:1]};
    endfunction

    function automatic logic [DIM-1:0] rot_l(input logic [DIM-1:0] v);
        return {v[DIM-2:0], v[DIM-1]};
    endfunction

    assign wb_en = s2_valid && (s2_instr.op == hdc_pkg::OP_WB);

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_instr <= issue;
        s2_instr <= s1_instr;
        // item read for the instruction in stage 1
        reg_0    <= item_mem[s1_instr.addr[IA_W-1:0]];
    end

    // single write port, generator has priority
    // the sequencer never runs during generation anyway
    always_ff @(posedge clk) begin
        if (gen_we) begin
            item_mem[gen_addr[IA_W-1:0]] <= gen_vec;
        end else if (wb_en) begin
            item_mem[s2_instr.addr[IA_W-1:0]] <= sign_vec;
        end
    end

    // strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
            last_out  <= 1'b0;
        end else begin
            res_valid <= s2_valid && (s2_instr.op == hdc_pkg::OP_STORE);
            last_out  <= s2_valid && (s2_instr.op == hdc_pkg::OP_LAST);
        end
    end

    // working registers
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            case (s2_instr.op)
                hdc_pkg::OP_LOAD: begin
                    reg_2 <= reg_0;
                end
                hdc_pkg::OP_LRSHIFT: begin
                    reg_2 <= rot_r(reg_0);
                end
                hdc_pkg::OP_LLSHIFT: begin
                    reg_2 <= rot_l(reg_0);
                end
                hdc_pkg::OP_LXOR: begin
                    reg_2 <= reg_0 ^ reg_2;
                end
                hdc_pkg::OP_RSHIFT: begin
                    reg_2 <= rot_r(reg_2);
                end
                hdc_pkg::OP_LSHIFT: begin
                    reg_2 <= rot_l(reg_2);
                end
                hdc_pkg::OP_XOR: begin
                    reg_2 <= reg_1 ^ reg_2;
                end
                hdc_pkg::OP_STORE: begin
                    res_vec <= reg_2;
                end
                hdc_pkg::OP_MOVE: begin
                    reg_1 <= reg_2;
                end
                hdc_pkg::OP_SIGN: begin
                    // majority from the last closed bundle
                    reg_2 <= sign_vec;
                end
                default: begin
                    // nop, halt, last and wb leave the registers alone
                end
            endcase
        end
    end

endmodule

/* hdl/item_generator.sv */
module item_generator #(
    parameter int          DIM   = 128,
    parameter int          ITEMS = 64,
    parameter logic [63:0] SEED  = hdc_pkg::XS_SEED_DEFAULT
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            gen,
    output logic                            gen_we,
    output logic [hdc_pkg::ITEM_ADDR_W-1:0] gen_addr,
    output logic [DIM-1:0]                  gen_vec,
    output logic                            gen_busy
);

    localparam int WPI    = DIM / 64;
    localparam int WCNT_W = (WPI > 1) ? $clog2(WPI) : 1;
    localparam int AW     = hdc_pkg::ITEM_ADDR_W;

    logic              active;
    logic [63:0]       state;
    logic [63:0]       word;
    logic [WCNT_W-1:0] word_cnt;
    logic [AW-1:0]     item_cnt;

    function automatic logic [63:0] xs_step(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    assign word     = xs_step(state);
    // still busy while the last item is being written
    assign gen_busy = active | gen_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            state    <= SEED;
            word_cnt <= '0;
            item_cnt <= '0;
            gen_we   <= 1'b0;
            gen_addr <= '0;
        end else begin
            gen_we <= 1'b0;
            if (gen && !gen_busy) begin
                active   <= 1'b1;
                state    <= SEED;
                word_cnt <= '0;
                item_cnt <= '0;
            end else if (active) begin
                state <= word;
                if (word_cnt == WCNT_W'(WPI - 1)) begin
                    // item complete, write it next cycle
                    word_cnt <= '0;
                    gen_we   <= 1'b1;
                    gen_addr <= item_cnt;
                    item_cnt <= item_cnt + 1'b1;
                    if (item_cnt == AW'(ITEMS - 1)) begin
                        active <= 1'b0;
                    end
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // words enter at the top and move down, so the first word ends up lowest
    always_ff @(posedge clk) begin
        if (active) begin
            gen_vec <= (gen_vec >> 64) | (DIM'(word) << (DIM - 64));
        end
    end

endmodule

/* hdl/hdc_pkg.sv */
package hdc_pkg;

    // instruction word layout
    localparam int INSTR_W     = 16;
    localparam int OPCODE_W    = 4;
    localparam int ITEM_ADDR_W = 10;
    localparam int SPARE_W     = INSTR_W - OPCODE_W - ITEM_ADDR_W;

    // default xorshift64 seed, must be nonzero
    localparam logic [63:0] XS_SEED_DEFAULT = 64'h9e37_79b9_7f4a_7c15;

    typedef enum logic [OPCODE_W-1:0] {
        OP_NOP     = 4'h0,
        OP_LOAD    = 4'h1,
        OP_LRSHIFT = 4'h2,
        OP_LLSHIFT = 4'h3,
        OP_LXOR    = 4'h4,
        // operate on reg_2 in place
        OP_RSHIFT  = 4'h5,
        OP_LSHIFT  = 4'h6,
        OP_XOR     = 4'h7,
        // output and bundle control
        OP_STORE   = 4'h8,
        OP_LAST    = 4'h9,
        OP_MOVE    = 4'ha,
        OP_SIGN    = 4'hb,
        OP_WB      = 4'hc,
        OP_HALT    = 4'hf
    } opcode_t;

    // op sits in the top nibble
    typedef struct packed {
        opcode_t                op;
        logic [ITEM_ADDR_W-1:0] addr;
        logic [SPARE_W-1:0]     spare;
    } instr_t;

endpackage
